// File: Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - decode_ctrl.sv
      - reg_file.sv
      - operand_fwd.sv
      - branch_unit.sv
      - id_ex_reg.sv
      - decode_stage.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_decode_stage.sv

// File: branch_unit.sv
// Branch resolution and next-PC select, all combinational in ID
// Compares the forwarded operands, so no branch waits on EX
`timescale 1ns/1ps

module branch_unit (
	input  isa_pkg::instr_t instr,
	input  pipe_pkg::ctrl_t ctrl,
	input  isa_pkg::addr_t  pca,
	input  isa_pkg::addr_t  cia,
	input  isa_pkg::word_t  fwdA,
	input  isa_pkg::word_t  fwdB,
	output isa_pkg::word_t  immExt,
	output logic            taken,
	output isa_pkg::addr_t  nextPc
);
	import isa_pkg::*;

	opcode_e opcode;
	logic    cond;
	addr_t   jumpTarget;
	addr_t   branchTarget;

	assign opcode = opcode_e'(instr[31:26]);

	assign immExt = ctrl.signExt ? {{16{instr[15]}}, instr[15:0]} : {16'h0000, instr[15:0]};

	// --------------------
	// Condition
	// --------------------
	always_comb begin
		case (opcode)
			OP_BEQ:  cond = (fwdA == fwdB);
			OP_BNE:  cond = (fwdA != fwdB);
			OP_BLEZ: cond = fwdA[31] || (fwdA == '0);
			OP_BGTZ: cond = !fwdA[31] && (fwdA != '0);
			default: cond = fwdA[31] ^ instr[16];  // REGIMM with rt bit 0 set means GEZ
		endcase
	end

	assign taken = ctrl.branch && cond;

	// --------------------
	// Targets
	// --------------------
	assign jumpTarget   = {cia[31:28], instr[25:0], 2'b00};   // Region of the jump itself
	assign branchTarget = pca + {immExt[29:0], 2'b00};

	always_comb begin
		if (ctrl.jump && ctrl.jumpReg) begin
			nextPc = fwdA;
		end else if (ctrl.jump) begin
			nextPc = jumpTarget;
		end else if (taken) begin
			nextPc = branchTarget;
		end else begin
			nextPc = pca;
		end
	end

endmodule

// File: decode_consts.svh
// Widths and fixed register numbers of the MIPS-I decode stage
// The bubble count must fit the counter width derived from it
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// --------------------
// Datapath widths
// --------------------

// Data word and byte address
`define WORD_W 32

// Register index, five bits for 32 registers
`define REG_IDX_W 5
`define REG_COUNT 32

// --------------------
// Fixed registers
// --------------------

// Return address target of JAL and the linking branches
`define LINK_REG 31

// Syscall argument register, v0
`define SYS_REG 2

// Idle cycles ahead of a syscall issue
`define SYS_BUBBLES 3

`endif

// File: decode_ctrl.sv
// Combinational decoder for the kept MIPS-I integer subset
// Unknown encodings give an all-zero control word plus illegal
`timescale 1ns/1ps

module decode_ctrl (
	input  isa_pkg::instr_t instr,
	output pipe_pkg::ctrl_t ctrl,
	output logic            illegal
);
	import isa_pkg::*;
	import pipe_pkg::*;

	opcode_e opcode;
	funct_e  funct;
	regimm_e rtCode;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);
	assign rtCode = regimm_e'(instr[20:16]);

	always_comb begin
		ctrl    = '0;
		illegal = 1'b0;
		case (opcode)
			// --------------------
			// SPECIAL, R-type
			// --------------------
			OP_SPECIAL: begin
				ctrl.regDst   = 1'b1;
				ctrl.regWrite = 1'b1;
				case (funct)
					FN_SLL:  ctrl.aluOp = ALU_SLL;
					FN_SRL:  ctrl.aluOp = ALU_SRL;
					FN_SRA:  ctrl.aluOp = ALU_SRA;
					FN_SLLV: ctrl.aluOp = ALU_SLLV;
					FN_SRLV: ctrl.aluOp = ALU_SRLV;
					FN_SRAV: ctrl.aluOp = ALU_SRAV;
					FN_ADD:  ctrl.aluOp = ALU_ADD;
					FN_ADDU: ctrl.aluOp = ALU_ADDU;
					FN_SUB:  ctrl.aluOp = ALU_SUB;
					FN_SUBU: ctrl.aluOp = ALU_SUBU;
					FN_AND:  ctrl.aluOp = ALU_AND;
					FN_OR:   ctrl.aluOp = ALU_OR;
					FN_XOR:  ctrl.aluOp = ALU_XOR;
					FN_NOR:  ctrl.aluOp = ALU_NOR;
					FN_SLT:  ctrl.aluOp = ALU_SLT;
					FN_SLTU: ctrl.aluOp = ALU_SLTU;
					FN_JR: begin
						ctrl.regDst   = 1'b0;
						ctrl.regWrite = 1'b0;
						ctrl.jump     = 1'b1;
						ctrl.jumpReg  = 1'b1;
					end
					FN_JALR: begin
						ctrl.link    = 1'b1;    // Return address into rd
						ctrl.jump    = 1'b1;
						ctrl.jumpReg = 1'b1;
					end
					FN_SYSCALL: begin
						ctrl.regDst  = 1'b0;    // Dest forced to r0 later
						ctrl.aluSrc  = 1'b1;
						ctrl.signExt = 1'b1;
						ctrl.syscall = 1'b1;
					end
					default: begin
						ctrl    = '0;
						illegal = 1'b1;
					end
				endcase
			end
			OP_REGIMM: begin
				if (rtCode inside {RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL}) begin
					ctrl.branch   = 1'b1;
					ctrl.signExt  = 1'b1;
					ctrl.link     = instr[20];  // AL forms
					ctrl.regWrite = instr[20];
				end else begin
					illegal = 1'b1;
				end
			end
			// --------------------
			// Branches and jumps
			// --------------------
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
				ctrl.branch  = 1'b1;
				ctrl.signExt = 1'b1;
			end
			OP_J: ctrl.jump = 1'b1;
			OP_JAL: begin
				ctrl.jump     = 1'b1;
				ctrl.link     = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			// --------------------
			// Immediate ALU
			// --------------------
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.signExt  = !(opcode inside {OP_ANDI, OP_ORI, OP_XORI});
				case (opcode)
					OP_ADDI:  ctrl.aluOp = ALU_ADD;
					OP_ADDIU: ctrl.aluOp = ALU_ADDU;
					OP_SLTI:  ctrl.aluOp = ALU_SLT;
					OP_SLTIU: ctrl.aluOp = ALU_SLTU;
					OP_ANDI:  ctrl.aluOp = ALU_AND;
					OP_ORI:   ctrl.aluOp = ALU_OR;
					OP_XORI:  ctrl.aluOp = ALU_XOR;
					default:  ctrl.aluOp = ALU_LUI;
				endcase
			end
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.signExt  = 1'b1;
				ctrl.aluOp    = ALU_ADDU;   // Address add, no overflow trap
			end
			OP_SB, OP_SH, OP_SW: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.signExt  = 1'b1;
				ctrl.aluOp    = ALU_ADDU;
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

// File: decode_stage.sv
// Decode stage of a five-stage MIPS-I integer pipeline
// nextPc and branchTaken settle in the same cycle as instr
`timescale 1ns/1ps

module decode_stage (
	input  logic            CLK,
	input  logic            RESET,
	input  logic            freeze,
	input  isa_pkg::instr_t instr,
	input  isa_pkg::addr_t  pca,
	input  isa_pkg::addr_t  cia,
	input  isa_pkg::word_t  exResult,
	input  pipe_pkg::fwd_t  memFwd,
	input  pipe_pkg::fwd_t  wbFwd,       // Also the register file write port
	output pipe_pkg::idEx_t idEx,
	output isa_pkg::addr_t  nextPc,
	output logic            branchTaken,
	output logic            insertBubble,
	output logic            sysIssue,
	output logic            illegal
);
	import isa_pkg::*;
	import pipe_pkg::*;

	ctrl_t ctrl;
	word_t regA;
	word_t regB;
	word_t dataSys;
	word_t fwdA;
	word_t fwdB;
	word_t immExt;
	fwd_t  exFwd;

	// EX forward, from the instruction held in ID/EX
	assign exFwd = '{valid: idEx.doWriteback, dest: idEx.dest, data: exResult};

	decode_ctrl u_ctrl (.instr(instr), .ctrl(ctrl), .illegal(illegal));

	reg_file u_regFile (
		.CLK(CLK), .rdA(instr[25:21]), .rdB(instr[20:16]),
		.dataA(regA), .dataB(regB), .dataSys(dataSys), .wb(wbFwd)
	);

	operand_fwd u_fwd (
		.srcA(instr[25:21]), .srcB(instr[20:16]), .regA(regA), .regB(regB),
		.exFwd(exFwd), .memFwd(memFwd), .wbFwd(wbFwd), .fwdA(fwdA), .fwdB(fwdB)
	);

	branch_unit u_branch (
		.instr(instr), .ctrl(ctrl), .pca(pca), .cia(cia), .fwdA(fwdA), .fwdB(fwdB),
		.immExt(immExt), .taken(branchTaken), .nextPc(nextPc)
	);

	id_ex_reg u_idEx (
		.CLK(CLK), .RESET(RESET), .freeze(freeze), .instr(instr), .ctrl(ctrl), .pca(pca),
		.regA(regA), .regB(regB), .dataSys(dataSys), .immExt(immExt), .taken(branchTaken),
		.insertBubble(insertBubble), .sysIssue(sysIssue), .idEx(idEx)
	);

endmodule

// File: id_ex_reg.sv
// ID/EX register with link and syscall operand substitution
// A syscall waits out the bubble count before it loads
// freeze holds both the register and the bubble counter
`timescale 1ns/1ps
`include "decode_consts.svh"

module id_ex_reg (
	input  logic            CLK,
	input  logic            RESET,
	input  logic            freeze,
	input  isa_pkg::instr_t instr,
	input  pipe_pkg::ctrl_t ctrl,
	input  isa_pkg::addr_t  pca,
	input  isa_pkg::word_t  regA,
	input  isa_pkg::word_t  regB,
	input  isa_pkg::word_t  dataSys,
	input  isa_pkg::word_t  immExt,
	input  logic            taken,
	output logic            insertBubble,
	output logic            sysIssue,
	output pipe_pkg::idEx_t idEx
);
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int CNT_W = $clog2(`SYS_BUBBLES + 1);

	logic [CNT_W-1:0] bubbleCnt;
	regIdx_t          dest;
	idEx_t            idExNext;

	assign dest = ctrl.regDst  ? instr[15:11] :
	              ctrl.link    ? regIdx_t'(`LINK_REG) :
	              ctrl.syscall ? '0 : instr[20:16];

	// --------------------
	// Next record
	// --------------------
	always_comb begin
		idExNext             = '0;
		idExNext.storeData   = regB;
		idExNext.instr       = instr;
		idExNext.dest        = dest;
		idExNext.shamt       = instr[10:6];
		idExNext.aluOp       = ctrl.aluOp;
		idExNext.memRead     = ctrl.memRead;
		idExNext.memWrite    = ctrl.memWrite;
		idExNext.memToReg    = ctrl.memToReg;
		idExNext.aluSrc      = ctrl.aluSrc;
		idExNext.doWriteback = (ctrl.regWrite && (dest != '0)) || ctrl.memToReg;
		idExNext.branchTaken = taken;
		if (ctrl.link) begin
			idExNext.opA = pca;             // EX adds 4 for the return address
			idExNext.opB = word_t'(4);
		end else if (ctrl.syscall) begin
			idExNext.opA = dataSys;
		end else begin
			idExNext.opA  = regA;
			idExNext.opB  = ctrl.aluSrc ? immExt : regB;
			idExNext.srcA = instr[25:21];
			idExNext.srcB = ctrl.aluSrc ? '0 : instr[20:16];
		end
	end

	// Syscall bubble handshake
	assign insertBubble = ctrl.syscall && (bubbleCnt != '0);
	assign sysIssue     = ctrl.syscall && (bubbleCnt == '0);

	always_ff @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			bubbleCnt <= CNT_W'(`SYS_BUBBLES);
			idEx      <= '0;
		end else if (!freeze) begin
			if (insertBubble) begin
				bubbleCnt <= bubbleCnt - 1'b1;
				idEx      <= '0;            // Bubble into EX
			end else begin
				bubbleCnt <= CNT_W'(`SYS_BUBBLES);
				idEx      <= idExNext;
			end
		end
	end

endmodule

// File: isa_pkg.sv
// MIPS-I integer instruction set types
// Only the kept opcodes and funct codes appear in the enums
`include "decode_consts.svh"

package isa_pkg;

	typedef logic [`WORD_W-1:0]    word_t;
	typedef logic [`WORD_W-1:0]    addr_t;
	typedef logic [`REG_IDX_W-1:0] regIdx_t;
	typedef logic [`WORD_W-1:0]    instr_t;

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0A, OP_SLTIU = 6'h0B,
		OP_ANDI    = 6'h0C, OP_ORI    = 6'h0D, OP_XORI  = 6'h0E, OP_LUI   = 6'h0F,
		OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
		OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2B
	} opcode_e;

	// SPECIAL funct field, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL     = 6'h00, FN_SRL    = 6'h02, FN_SRA   = 6'h03,
		FN_SLLV    = 6'h04, FN_SRLV   = 6'h06, FN_SRAV  = 6'h07,
		FN_JR      = 6'h08, FN_JALR   = 6'h09, FN_SYSCALL = 6'h0C,
		FN_ADD     = 6'h20, FN_ADDU   = 6'h21, FN_SUB   = 6'h22, FN_SUBU = 6'h23,
		FN_AND     = 6'h24, FN_OR     = 6'h25, FN_XOR   = 6'h26, FN_NOR  = 6'h27,
		FN_SLT     = 6'h2A, FN_SLTU   = 6'h2B
	} funct_e;

	// REGIMM rt field, bits 20:16
	// Bit 0 selects GEZ over LTZ, bit 4 the linking form
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_e;

endpackage

// File: operand_fwd.sv
// Branch and jump operand forwarding
// Priority EX, then MEM, then WB, then the register file
`timescale 1ns/1ps

module operand_fwd (
	input  isa_pkg::regIdx_t srcA,
	input  isa_pkg::regIdx_t srcB,
	input  isa_pkg::word_t   regA,
	input  isa_pkg::word_t   regB,
	input  pipe_pkg::fwd_t   exFwd,
	input  pipe_pkg::fwd_t   memFwd,
	input  pipe_pkg::fwd_t   wbFwd,
	output isa_pkg::word_t   fwdA,
	output isa_pkg::word_t   fwdB
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// Newest matching producer wins
	function automatic word_t pick(input regIdx_t src, input word_t fileVal,
			input fwd_t ex, input fwd_t mem, input fwd_t wb);
		if (src == '0) begin
			return fileVal;                 // r0 never forwarded
		end else if (ex.valid && (ex.dest == src)) begin
			return ex.data;
		end else if (mem.valid && (mem.dest == src)) begin
			return mem.data;
		end else if (wb.valid && (wb.dest == src)) begin
			return wb.data;
		end
		return fileVal;
	endfunction

	assign fwdA = pick(srcA, regA, exFwd, memFwd, wbFwd);
	assign fwdB = pick(srcB, regB, exFwd, memFwd, wbFwd);

endmodule

// File: pipe_pkg.sv
// Pipeline records passed between decode and the later stages
// ALU operation codes are local to this pipeline, not to the ISA
package pipe_pkg;

	// One code per ALU action; links and syscall reuse ALU_ADD
	typedef enum logic [4:0] {
		ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_SLLV, ALU_SRLV, ALU_SRAV,
		ALU_LUI
	} aluOp_e;

	// Decoded control word
	typedef struct packed {
		logic   link;       // Writes return address
		logic   regDst;     // rd is the destination
		logic   jump;
		logic   branch;
		logic   memRead;
		logic   memToReg;
		logic   memWrite;
		logic   aluSrc;     // Immediate as operand B
		logic   regWrite;
		logic   jumpReg;    // Target from rs
		logic   signExt;
		logic   syscall;
		aluOp_e aluOp;
	} ctrl_t;

	// Result bus of a later stage, also the register file write port
	typedef struct packed {
		logic             valid;
		isa_pkg::regIdx_t dest;
		isa_pkg::word_t   data;
	} fwd_t;

	// ID/EX pipeline register
	typedef struct packed {
		isa_pkg::word_t   opA;
		isa_pkg::word_t   opB;
		isa_pkg::word_t   storeData;
		isa_pkg::instr_t  instr;
		isa_pkg::regIdx_t dest;
		isa_pkg::regIdx_t srcA;     // Zero when opA needs no forward in EX
		isa_pkg::regIdx_t srcB;
		logic [4:0]       shamt;
		aluOp_e           aluOp;
		logic             memRead;
		logic             memWrite;
		logic             memToReg;
		logic             aluSrc;
		logic             doWriteback;
		logic             branchTaken;
	} idEx_t;

endpackage

// File: reg_file.sv
// 32 x 32 register file, three read ports, one write port
// No reset; r0 is never written and reads as zero
// Same-cycle write and read returns the old value
`timescale 1ns/1ps
`include "decode_consts.svh"

module reg_file (
	input  logic             CLK,
	input  isa_pkg::regIdx_t rdA,
	input  isa_pkg::regIdx_t rdB,
	output isa_pkg::word_t   dataA,
	output isa_pkg::word_t   dataB,
	output isa_pkg::word_t   dataSys,
	input  pipe_pkg::fwd_t   wb
);
	import isa_pkg::*;

	word_t regs [`REG_COUNT];

	// Write port shared with the WB forward bus
	always_ff @(posedge CLK) begin
		if (wb.valid && (wb.dest != '0)) begin
			regs[wb.dest] <= wb.data;
		end
	end

	assign dataA = (rdA == '0) ? '0 : regs[rdA];
	assign dataB = (rdB == '0) ? '0 : regs[rdB];

	// Syscall argument, fixed index
	assign dataSys = regs[`SYS_REG];

endmodule

// File: tb.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
decode_ctrl.sv
reg_file.sv
operand_fwd.sv
branch_unit.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// File: tb_decode_stage.sv
// Self-checking testbench for decode_stage against a reference decode model
// Registers are unknown until loaded through wbFwd after reset
`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_decode_stage;
	import isa_pkg::*;
	import pipe_pkg::*;

	localparam int     TEST_CYCLES  = 10 + 32 + 51 + 37 + 131 + 35 + 12 + 20;
	localparam instr_t SYSCALL_WORD = 32'h0000_000C;

	logic    CLK = 1'b0;
	logic    RESET;
	logic    freeze;
	instr_t  instr;
	addr_t   pca;
	addr_t   cia;
	word_t   exResult;
	fwd_t    memFwd;
	fwd_t    wbFwd;
	idEx_t   idEx;
	addr_t   nextPc;
	logic    branchTaken;
	logic    insertBubble;
	logic    sysIssue;
	logic    illegal;

	integer  seed = 95;
	int      errors = 0;
	int      checks = 0;
	int      tests = 0;
	int      testStart = 0;
	word_t   pool [4] = '{32'h0000_0000, 32'h0000_0005, 32'hFFFF_FFF0, 32'h8000_0000};
	logic [5:0] aluFuncts [16] = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21,
	                               6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27, 6'h2A, 6'h2B};

	// Reference state
	word_t      refRegs [`REG_COUNT];
	idEx_t      refIdEx;
	logic [2:0] refCnt;
	word_t      refA;
	word_t      refB;
	logic       refTaken;
	addr_t      refNextPc;
	logic       refSys;
	logic       refIllegal;

	always #5 CLK = ~CLK;

	decode_stage u_dut (
		.CLK(CLK), .RESET(RESET), .freeze(freeze), .instr(instr), .pca(pca), .cia(cia),
		.exResult(exResult), .memFwd(memFwd), .wbFwd(wbFwd), .idEx(idEx), .nextPc(nextPc),
		.branchTaken(branchTaken), .insertBubble(insertBubble), .sysIssue(sysIssue),
		.illegal(illegal)
	);

	// --------------------
	// Reference model
	// --------------------
	function automatic word_t readReg(input regIdx_t idx);
		return (idx == '0) ? '0 : refRegs[idx];
	endfunction

	// Newest producer first and r0 never forwarded
	function automatic word_t expectOperand(input regIdx_t src);
		if (src == '0) return '0;
		if (refIdEx.doWriteback && (refIdEx.dest == src)) return exResult;
		if (memFwd.valid && (memFwd.dest == src)) return memFwd.data;
		if (wbFwd.valid && (wbFwd.dest == src)) return wbFwd.data;
		return readReg(src);
	endfunction

	function automatic aluOp_e expectAluOp(input logic [5:0] op, input logic [5:0] fn);
		case (op)
			6'h00: begin
				case (fn)
					6'h00:   return ALU_SLL;
					6'h02:   return ALU_SRL;
					6'h03:   return ALU_SRA;
					6'h04:   return ALU_SLLV;
					6'h06:   return ALU_SRLV;
					6'h07:   return ALU_SRAV;
					6'h21:   return ALU_ADDU;
					6'h22:   return ALU_SUB;
					6'h23:   return ALU_SUBU;
					6'h24:   return ALU_AND;
					6'h25:   return ALU_OR;
					6'h26:   return ALU_XOR;
					6'h27:   return ALU_NOR;
					6'h2A:   return ALU_SLT;
					6'h2B:   return ALU_SLTU;
					default: return ALU_ADD;  // ADD, jumps, syscall, unknown
				endcase
			end
			6'h09:   return ALU_ADDU;
			6'h0A:   return ALU_SLT;
			6'h0B:   return ALU_SLTU;
			6'h0C:   return ALU_AND;
			6'h0D:   return ALU_OR;
			6'h0E:   return ALU_XOR;
			6'h0F:   return ALU_LUI;
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29, 6'h2B: return ALU_ADDU;
			default: return ALU_ADD;
		endcase
	endfunction

	function automatic idEx_t expectRecord(input instr_t in, input addr_t pc, input logic tk);
		idEx_t      r;
		logic [5:0] op;
		logic [5:0] fn;
		logic       rAlu, jalr, sys, imm, load, store, linkOp, useImm, wr;
		word_t      ext;
		op     = in[31:26];
		fn     = in[5:0];
		rAlu   = (op == 6'h00) && (fn inside {6'h00, [6'h02:6'h04], [6'h06:6'h07],
		                                      [6'h20:6'h27], 6'h2A, 6'h2B});
		jalr   = (op == 6'h00) && (fn == 6'h09);
		sys    = (op == 6'h00) && (fn == 6'h0C);
		imm    = op inside {[6'h08:6'h0F]};
		load   = op inside {6'h20, 6'h21, 6'h23, 6'h24, 6'h25};
		store  = op inside {6'h28, 6'h29, 6'h2B};
		linkOp = jalr || (op == 6'h03) || ((op == 6'h01) && (in[20:16] inside {5'h10, 5'h11}));
		useImm = imm || load || store || sys;
		wr     = rAlu || linkOp || imm || load;
		ext    = (op inside {[6'h0C:6'h0E]}) ? {16'h0000, in[15:0]} : {{16{in[15]}}, in[15:0]};
		r               = '0;
		r.dest          = (rAlu || jalr) ? in[15:11] :
		                  linkOp ? regIdx_t'(`LINK_REG) : sys ? '0 : in[20:16];
		r.storeData     = readReg(in[20:16]);
		r.instr         = in;
		r.shamt         = in[10:6];
		r.aluOp         = expectAluOp(op, fn);
		r.memRead       = load;
		r.memToReg      = load;
		r.memWrite      = store;
		r.aluSrc        = useImm;
		r.doWriteback   = (wr && (r.dest != '0)) || load;
		r.branchTaken   = tk;
		if (linkOp) begin
			r.opA = pc;
			r.opB = 32'd4;
		end else if (sys) begin
			r.opA = refRegs[`SYS_REG];
		end else begin
			r.opA  = readReg(in[25:21]);
			r.opB  = useImm ? ext : readReg(in[20:16]);
			r.srcA = in[25:21];
			r.srcB = useImm ? '0 : in[20:16];
		end
		return r;
	endfunction

	// Branch condition and next PC in the same cycle as instr
	always_comb begin
		refA = expectOperand(instr[25:21]);
		refB = expectOperand(instr[20:16]);
		case (instr[31:26])
			6'h01:   refTaken = (instr[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11}) &&
			                    (instr[16] ? !refA[31] : refA[31]);
			6'h04:   refTaken = (refA == refB);
			6'h05:   refTaken = (refA != refB);
			6'h06:   refTaken = ($signed(refA) <= 0);
			6'h07:   refTaken = ($signed(refA) > 0);
			default: refTaken = 1'b0;
		endcase
		if ((instr[31:26] == 6'h00) && (instr[5:1] == 5'b00100)) begin
			refNextPc = refA;                               // JR, JALR
		end else if (instr[31:27] == 5'b00001) begin
			refNextPc = {cia[31:28], instr[25:0], 2'b00};   // J, JAL
		end else if (refTaken) begin
			refNextPc = pca + {{14{instr[15]}}, instr[15:0], 2'b00};
		end else begin
			refNextPc = pca;
		end
	end

	assign refSys     = (instr[31:26] == 6'h00) && (instr[5:0] == 6'h0C);
	assign refIllegal = (instr[31:26] == 6'h00) ?
	                    !(instr[5:0] inside {6'h00, [6'h02:6'h04], [6'h06:6'h09], 6'h0C,
	                                         [6'h20:6'h27], 6'h2A, 6'h2B}) :
	                    (instr[31:26] == 6'h01) ?
	                    !(instr[20:16] inside {5'h00, 5'h01, 5'h10, 5'h11}) :
	                    !(instr[31:26] inside {[6'h02:6'h0F], [6'h20:6'h21], [6'h23:6'h25],
	                                           [6'h28:6'h29], 6'h2B});

	always @(posedge CLK or negedge RESET) begin
		if (!RESET) begin
			refIdEx <= '0;
			refCnt  <= `SYS_BUBBLES;
		end else if (!freeze) begin
			if (refSys && (refCnt != 0)) begin
				refIdEx <= '0;          // Bubble
				refCnt  <= refCnt - 1'b1;
			end else begin
				refIdEx <= expectRecord(instr, pca, refTaken);
				refCnt  <= `SYS_BUBBLES;
			end
		end
	end

	always @(posedge CLK) begin
		if (wbFwd.valid && (wbFwd.dest != '0)) begin
			refRegs[wbFwd.dest] <= wbFwd.data;
		end
	end

	// --------------------
	// Checks
	// --------------------
	recordCheck: assert property (@(posedge CLK) disable iff (!RESET) idEx == refIdEx)
		checks++;
	else begin
		errors++;
		$display("Error at %0t: idEx %h, expected %h", $time, $sampled(idEx), $sampled(refIdEx));
	end

	branchCheck: assert property (@(posedge CLK) disable iff (!RESET)
			(nextPc == refNextPc) && (branchTaken == refTaken))
		checks++;
	else begin
		errors++;
		$display("Error at %0t: nextPc %h taken %b, expected %h %b", $time, $sampled(nextPc),
			$sampled(branchTaken), $sampled(refNextPc), $sampled(refTaken));
	end

	handshakeCheck: assert property (@(posedge CLK) disable iff (!RESET)
			(insertBubble == (refSys && (refCnt != 0))) && (sysIssue == (refSys && (refCnt == 0))))
		checks++;
	else begin
		errors++;
		$display("Error at %0t: insertBubble %b sysIssue %b, bubble count %0d", $time,
			$sampled(insertBubble), $sampled(sysIssue), $sampled(refCnt));
	end

	illegalCheck: assert property (@(posedge CLK) disable iff (!RESET) illegal == refIllegal)
		checks++;
	else begin
		errors++;
		$display("Error at %0t: illegal %b for instr %h", $time, $sampled(illegal), $sampled(instr));
	end

	// --------------------
	// Stimulus helpers
	// --------------------
	task automatic step(input instr_t in, input fwd_t mem, input fwd_t wb, input logic frz);
		@(posedge CLK);
		instr    <= in;
		memFwd   <= mem;
		wbFwd    <= wb;
		freeze   <= frz;
		pca      <= $random(seed);
		cia      <= $random(seed);
		exResult <= pool[$random(seed) & 3];
	endtask

	task automatic finishTest(input string name);
		repeat (2) begin
			step('0, '0, '0, 1'b0);
		end
		@(negedge CLK);   // Let the last checks land
		tests++;
		$display("Test %0d, %s: %0d errors", tests, name, errors - testStart);
		testStart = errors;
	endtask

	// Counts bubble cycles of a syscall held in ID up to sysIssue
	task automatic awaitIssue(input int expected);
		int bubbles;
		int waited;
		bubbles = 0;
		waited  = 0;
		@(negedge CLK);
		while (!sysIssue && (waited < 20)) begin
			if (insertBubble) begin
				bubbles++;
			end
			@(negedge CLK);
			waited++;
		end
		issueCheck: assert (sysIssue) else begin
			errors++;
			$display("Syscall was never issued after %0d cycles of waiting", waited);
		end
		countCheck: assert (bubbles == expected) else begin
			errors++;
			$display("Error at %0t: %0d bubble cycles, expected %0d", $time, bubbles, expected);
		end
		step('0, '0, '0, 1'b0);   // Syscall record loads here
	endtask

	// --------------------
	// Tests
	// --------------------
	initial begin
		word_t      word;
		word_t      pick;
		regIdx_t    rs;
		regIdx_t    rt;
		logic [2:0] kind;
		RESET    = 1'b0;
		freeze   = 1'b0;
		instr    = '0;
		pca      = '0;
		cia      = '0;
		exResult = '0;
		memFwd   = '0;
		wbFwd    = '0;
		repeat (10) @(posedge CLK);
		RESET <= 1'b1;
		for (int i = 1; i < `REG_COUNT; i++) begin
			step('0, '0, '{valid: 1'b1, dest: regIdx_t'(i), data: word_t'($random(seed))}, 1'b0);
		end
		step('0, '0, '0, 1'b0);

		for (int i = 0; i < 48; i++) begin
			word = $random(seed);
			pick = $random(seed);
			if (i % 2 == 0) begin
				word[31:26] = 6'h00;
				word[5:0]   = aluFuncts[pick[3:0]];
			end else begin
				word[31:26] = {3'b001, word[28:26]};
			end
			if (i % 8 < 2) begin
				word[20:16] = '0;     // Immediate into r0
				word[15:11] = '0;
			end
			step(word, '0, '0, 1'b0);
		end
		finishTest("ALU and immediate decode");

		for (int i = 0; i < 32; i++) begin
			word = $random(seed);
			pick = $random(seed);
			case (pick[2:0])
				3'd0: word[31:26] = 6'h20;
				3'd1: word[31:26] = 6'h21;
				3'd2: word[31:26] = 6'h23;
				3'd3: word[31:26] = 6'h24;
				3'd4: word[31:26] = 6'h25;
				3'd5: word[31:26] = 6'h28;
				3'd6: word[31:26] = 6'h29;
				default: word[31:26] = 6'h2B;
			endcase
			if (i % 4 == 3) begin
				word[31:26] = pick[4] ? 6'h11 : 6'h22;   // COP1 and LWL are dropped
			end
			step(word, '0, '0, 1'b0);
		end
		step({6'h00, 20'h12345, 6'h0D}, '0, '0, 1'b0);  // BREAK
		step({6'h01, 5'd3, 5'h02, 16'h0010}, '0, '0, 1'b0);  // BLTZL
		finishTest("loads, stores and illegal");

		for (int i = 0; i < 64; i++) begin
			pick = $random(seed);
			rs   = (pick[4:0] == '0) ? 5'd1 : pick[4:0];
			rt   = (pick[9:5] == '0) ? 5'd2 : pick[9:5];
			kind = i[2:0];
			step({6'h09, 5'd0, pick[10] ? rs : rt, 16'h0001}, '0, '0, 1'b0);  // EX producer
			if (!kind[2]) begin
				word = {4'b0001, kind[1:0], rs, rt, pick[31:16]};
			end else begin
				word = {6'h01, rs, kind[1], 3'b000, kind[0], pick[31:16]};
			end
			step(word, '{valid: pick[11], dest: pick[12] ? rs : rt, data: pool[pick[14:13]]},
				'{valid: pick[15], dest: pick[16] ? rs : rt, data: pool[pick[18:17]]}, 1'b0);
		end
		finishTest("branch forwarding");

		for (int i = 0; i < 15; i++) begin
			pick = $random(seed);
			rs   = pick[4:0];
			step({6'h09, 5'd0, rs, 16'h0010}, '0, '0, 1'b0);
			case (i % 5)
				0: word = {6'h02, pick[31:6]};
				1: word = {6'h03, pick[31:6]};
				2: word = {6'h00, rs, 15'h0000, 6'h08};
				3: word = {6'h00, rs, 5'd0, pick[15:11], 5'd0, 6'h09};
				default: word = {6'h01, rs, 5'h11, pick[31:16]};
			endcase
			step(word, '{valid: pick[5], dest: rs, data: pool[pick[7:6]]}, '0, 1'b0);
		end
		finishTest("jumps and links");

		step('0, '0, '{valid: 1'b1, dest: regIdx_t'(`SYS_REG), data: 32'h0000_0FA5}, 1'b0);
		step(SYSCALL_WORD, '0, '0, 1'b0);
		awaitIssue(`SYS_BUBBLES);
		finishTest("syscall bubbles");

		step(SYSCALL_WORD, '0, '0, 1'b0);
		for (int i = 0; i < 5; i++) begin
			step($random(seed), '0, '0, 1'b1);   // Held while instr changes
		end
		step(SYSCALL_WORD, '0, '0, 1'b0);
		awaitIssue(`SYS_BUBBLES - 1);
		finishTest("freeze");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#((TEST_CYCLES + 200) * 10);
		$display("Timeout: the run did not finish in the expected number of cycles");
		$display("Errors found");
		$finish;
	end

endmodule
